// File: bridge_decode.sv
/*
  region decode for the host bridge, all on clk_74a
  command block aliases every 16 bytes, only address bits [3:2] select a word
  read data is registered, valid the cycle after bridge_rd and held until the next read
*/
`timescale 1ns/100ps

module bridge_decode (
  input  logic                          clk_74a,
  input  logic                          rst_n,
  input  logic [core_pkg::bridge_w-1:0] bridge_addr,
  input  logic                          bridge_rd,
  input  logic                          bridge_wr,
  input  logic [core_pkg::bridge_w-1:0] status,
  output logic [core_pkg::bridge_w-1:0] bridge_rd_data,
  output logic                          cmd_wr,
  output logic [1:0]                    cmd_ofs,
  output logic                          load_wr,
  output logic [core_pkg::mem_aw-1:0]   load_addr
);

  logic in_cmd;
  logic in_load;

  // one compare per region
  assign in_cmd = bridge_addr[31:24] == core_pkg::region_cmd;
  assign in_load = bridge_addr[31:28] == core_pkg::region_load;

  // byte address to word offset
  assign cmd_ofs = bridge_addr[3:2];
  assign load_addr = bridge_addr[core_pkg::mem_aw+1:2];

  // per-region write strobes
  assign cmd_wr = bridge_wr & in_cmd;
  assign load_wr = bridge_wr & in_load;

  ////////////////////
  // read mux

  // load region and unmapped space read back as zero
  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      bridge_rd_data <= '0;
    end else if (bridge_rd) begin
      if (in_cmd && cmd_ofs == core_pkg::cmd_status_ofs) begin
        bridge_rd_data <= status;
      end else begin
        bridge_rd_data <= '0;
      end
    end
  end

endmodule

// File: core_pkg.sv
/*
  shared sizes, bridge region codes and state types for the bridge side
  command offsets are word offsets, taken from bridge address bits [3:2]
  load fifo depth must stay a power of two
*/
package core_pkg;

  ////////////////////
  // bus and memory sizes

  // bridge address and data width
  localparam int bridge_w = 32;
  // word address into the shared ram
  localparam int mem_aw = 10;
  localparam int mem_words = 1024;

  ////////////////////
  // bridge regions

  // load region, upper nibble of the byte address
  localparam logic [3:0] region_load = 4'h1;
  // host command block, upper byte
  localparam logic [7:0] region_cmd = 8'hF8;

  // word offsets inside the command block
  localparam logic [1:0] cmd_status_ofs = 2'd0;
  localparam logic [1:0] cmd_dl_start_ofs = 2'd1;
  localparam logic [1:0] cmd_dl_done_ofs = 2'd2;

  ////////////////////
  // reset hold and loader

  // button reset length in clk_74a cycles
  localparam logic [15:0] reset_hold_cycles = 16'd64;
  // entries in the load buffer
  localparam int load_fifo_depth = 4;

  ////////////////////
  // arbiter types

  // core port state, done is the cycle after a completion
  typedef enum logic [1:0] {idle, wait_grant, read_data, done} apb_state_t;

  // owner of the ram for the current cycle
  typedef enum logic [1:0] {grant_none, grant_loader, grant_core} grant_t;

endpackage

// File: core_top.sv
/*
  bridge side of the core: region decode, command block, slot loader,
  ram arbiter and shared word ram, single clock clk_74a
  apb port is the soft core bus master, paddr is a word address
*/
`timescale 1ns/100ps

module core_top (
  input  logic                          clk_74a,
  input  logic                          rst_n,
  // host bridge
  input  logic [core_pkg::bridge_w-1:0] bridge_addr,
  input  logic                          bridge_rd,
  output logic [core_pkg::bridge_w-1:0] bridge_rd_data,
  input  logic                          bridge_wr,
  input  logic [core_pkg::bridge_w-1:0] bridge_wr_data,
  input  logic                          reset_button,
  // core bus
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [core_pkg::mem_aw-1:0]   paddr,
  input  logic [core_pkg::bridge_w-1:0] pwdata,
  output logic [core_pkg::bridge_w-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          core_reset
);

  // decode to command block
  logic                          cmd_wr;
  logic [1:0]                    cmd_ofs;
  logic [core_pkg::bridge_w-1:0] status;
  // decode to loader
  logic                          load_wr;
  logic [core_pkg::mem_aw-1:0]   load_addr;
  // loader request
  logic                          ld_req;
  logic                          ld_gnt;
  logic [core_pkg::mem_aw-1:0]   ld_addr;
  logic [core_pkg::bridge_w-1:0] ld_data;
  // ram port
  logic                          ram_we;
  logic [core_pkg::mem_aw-1:0]   ram_addr;
  logic [core_pkg::bridge_w-1:0] ram_wdata;
  logic [core_pkg::bridge_w-1:0] ram_rdata;

  ////////////////////
  // bridge side

  bridge_decode i_bridge_decode (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .status         (status),
    .bridge_rd_data (bridge_rd_data),
    .cmd_wr         (cmd_wr),
    .cmd_ofs        (cmd_ofs),
    .load_wr        (load_wr),
    .load_addr      (load_addr)
  );

  host_cmd_regs i_host_cmd_regs (
    .clk_74a      (clk_74a),
    .rst_n        (rst_n),
    .cmd_wr       (cmd_wr),
    .cmd_ofs      (cmd_ofs),
    .reset_button (reset_button),
    .core_reset   (core_reset),
    .status       (status)
  );

  // write data goes straight to the loader buffer
  slot_loader i_slot_loader (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .load_wr        (load_wr),
    .load_addr      (load_addr),
    .bridge_wr_data (bridge_wr_data),
    .ld_req         (ld_req),
    .ld_addr        (ld_addr),
    .ld_data        (ld_data),
    .ld_gnt         (ld_gnt)
  );

  ////////////////////
  // memory side

  mem_arbiter i_mem_arbiter (
    .clk_74a    (clk_74a),
    .rst_n      (rst_n),
    .ld_req     (ld_req),
    .ld_addr    (ld_addr),
    .ld_data    (ld_data),
    .ld_gnt     (ld_gnt),
    .core_reset (core_reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_rdata  (ram_rdata)
  );

  word_ram i_word_ram (
    .clk_74a (clk_74a),
    .we      (ram_we),
    .addr    (ram_addr),
    .wdata   (ram_wdata),
    .rdata   (ram_rdata)
  );

endmodule

// File: filelist.f
core_pkg.sv
bridge_decode.sv
host_cmd_regs.sv
slot_loader.sv
mem_arbiter.sv
word_ram.sv
core_top.sv
tb_core_top.sv

// File: host_cmd_regs.sv
/*
  host command block: download flag, button reset hold and status word
  core_reset also follows rst_n directly
  a button edge during a running hold restarts the full hold
*/
`timescale 1ns/100ps

module host_cmd_regs (
  input  logic                          clk_74a,
  input  logic                          rst_n,
  input  logic                          cmd_wr,
  input  logic [1:0]                    cmd_ofs,
  input  logic                          reset_button,
  output logic                          core_reset,
  output logic [core_pkg::bridge_w-1:0] status
);

  logic        dl_active;
  logic        button_prev;
  logic        button_rise;
  logic [15:0] hold_timer;

  ////////////////////
  // download flag

  // start wins if both offsets were somehow seen, they cannot be in one write
  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      dl_active <= 1'b0;
    end else if (cmd_wr && cmd_ofs == core_pkg::cmd_dl_start_ofs) begin
      dl_active <= 1'b1;
    end else if (cmd_wr && cmd_ofs == core_pkg::cmd_dl_done_ofs) begin
      dl_active <= 1'b0;
    end
  end

  ////////////////////
  // button reset hold

  assign button_rise = reset_button & ~button_prev;

  // previous button level for the edge
  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      button_prev <= 1'b0;
    end else begin
      button_prev <= reset_button;
    end
  end

  // loads on the edge, then counts down to zero
  // nonzero for exactly reset_hold_cycles cycles
  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      hold_timer <= '0;
    end else if (button_rise) begin
      hold_timer <= core_pkg::reset_hold_cycles;
    end else if (hold_timer != '0) begin
      hold_timer <= hold_timer - 16'd1;
    end
  end

  ////////////////////
  // outputs

  assign core_reset = !rst_n || dl_active || (hold_timer != '0);

  // bit 0 download, bit 1 core reset
  assign status = {{(core_pkg::bridge_w - 2){1'b0}}, core_reset, dl_active};

  // count stays inside the hold window
  a_timer_bound: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    hold_timer <= core_pkg::reset_hold_cycles
  );

endmodule

// File: mem_arbiter.sv
/*
  fixed-priority ram arbiter, loader first, core apb port second
  core write completes in its grant cycle, read one cycle later with prdata
  any core access phase seen during core_reset ends at once with pslverr
*/
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                          clk_74a,
  input  logic                          rst_n,
  input  logic                          ld_req,
  input  logic [core_pkg::mem_aw-1:0]   ld_addr,
  input  logic [core_pkg::bridge_w-1:0] ld_data,
  output logic                          ld_gnt,
  input  logic                          core_reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [core_pkg::mem_aw-1:0]   paddr,
  input  logic [core_pkg::bridge_w-1:0] pwdata,
  output logic [core_pkg::bridge_w-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          ram_we,
  output logic [core_pkg::mem_aw-1:0]   ram_addr,
  output logic [core_pkg::bridge_w-1:0] ram_wdata,
  input  logic [core_pkg::bridge_w-1:0] ram_rdata
);

  core_pkg::apb_state_t state;
  core_pkg::apb_state_t state_nxt;
  core_pkg::grant_t     grant;

  logic setup;
  logic access;
  logic core_gnt;
  logic core_err;

  // apb phases
  assign setup = psel & ~penable;
  assign access = psel & penable;

  ////////////////////
  // grant

  // loader always first, core only while waiting in its access phase
  always_comb begin
    grant = core_pkg::grant_none;
    if (ld_req) begin
      grant = core_pkg::grant_loader;
    end else if (state == core_pkg::wait_grant && access && !core_reset) begin
      grant = core_pkg::grant_core;
    end
  end

  assign ld_gnt = grant == core_pkg::grant_loader;
  assign core_gnt = grant == core_pkg::grant_core;

  // error ends the transfer whatever the loader does
  assign core_err = state == core_pkg::wait_grant && access && core_reset;

  ////////////////////
  // core port fsm

  always_comb begin
    state_nxt = state;
    case (state)
      // a new setup may follow a completion directly
      core_pkg::idle, core_pkg::done: begin
        state_nxt = setup ? core_pkg::wait_grant : core_pkg::idle;
      end
      core_pkg::wait_grant: begin
        if (!psel) begin
          state_nxt = core_pkg::idle;
        end else if (core_err || (core_gnt && pwrite)) begin
          state_nxt = core_pkg::done;
        end else if (core_gnt) begin
          state_nxt = core_pkg::read_data;
        end
      end
      // ram read data arrives here
      core_pkg::read_data: begin
        state_nxt = core_pkg::done;
      end
      default: begin
        state_nxt = core_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      state <= core_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // completion and ram drive

  assign pready = core_err | (core_gnt & pwrite) | (state == core_pkg::read_data);
  assign pslverr = core_err;
  assign prdata = (state == core_pkg::read_data) ? ram_rdata : '0;

  assign ram_we = ld_gnt | (core_gnt & pwrite);
  assign ram_addr = ld_gnt ? ld_addr : paddr;
  assign ram_wdata = ld_gnt ? ld_data : pwdata;

  // single owner per cycle
  a_grant_onehot: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    $onehot0({ld_gnt, core_gnt})
  );

  // loader request always shuts the core out
  a_loader_first: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    ld_req |-> !core_gnt
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_core_top \
  -f filelist.f -o sim_core > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: slot_loader.sv
/*
  buffers load-region bridge writes as address and data pairs
  relies on the arbiter granting every request in its first cycle,
  so one bridge write per cycle never fills the fifo
*/
`timescale 1ns/100ps

module slot_loader (
  input  logic                          clk_74a,
  input  logic                          rst_n,
  input  logic                          load_wr,
  input  logic [core_pkg::mem_aw-1:0]   load_addr,
  input  logic [core_pkg::bridge_w-1:0] bridge_wr_data,
  output logic                          ld_req,
  output logic [core_pkg::mem_aw-1:0]   ld_addr,
  output logic [core_pkg::bridge_w-1:0] ld_data,
  input  logic                          ld_gnt
);

  // entry storage
  logic [core_pkg::mem_aw-1:0]   addr_q [core_pkg::load_fifo_depth];
  logic [core_pkg::bridge_w-1:0] data_q [core_pkg::load_fifo_depth];

  // pointers wrap on their own, depth is a power of two
  logic [$clog2(core_pkg::load_fifo_depth)-1:0] wr_ptr;
  logic [$clog2(core_pkg::load_fifo_depth)-1:0] rd_ptr;
  logic [$clog2(core_pkg::load_fifo_depth):0]   count;

  logic push;
  logic pop;
  logic full;
  logic empty;

  assign empty = count == '0;
  assign full = count == ($clog2(core_pkg::load_fifo_depth) + 1)'(core_pkg::load_fifo_depth);
  assign push = load_wr;
  assign pop = ld_gnt & ~empty;

  ////////////////////
  // fifo control

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload only
  always_ff @(posedge clk_74a) begin
    if (push) begin
      addr_q[wr_ptr] <= load_addr;
      data_q[wr_ptr] <= bridge_wr_data;
    end
  end

  ////////////////////
  // memory request

  // head entry held until granted
  assign ld_req = ~empty;
  assign ld_addr = addr_q[rd_ptr];
  assign ld_data = data_q[rd_ptr];

  // a bridge write never lands on a full buffer
  a_no_overflow: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    push |-> !full
  );

endmodule

// File: tb_core_top.sv
/*
  testbench for the bridge side, one clock, inputs change on the falling edge
  ram words are read back only after a write, unwritten words are undefined
  paddr is a word address, bridge addresses are byte addresses
*/
`timescale 1ns/100ps

module tb_core_top;

  // about 1000 cycles of tests, with a wide margin
  localparam int timeout_cycles = 20000;

  logic                          clk_74a;
  logic                          rst_n;
  logic [core_pkg::bridge_w-1:0] bridge_addr;
  logic                          bridge_rd;
  logic [core_pkg::bridge_w-1:0] bridge_rd_data;
  logic                          bridge_wr;
  logic [core_pkg::bridge_w-1:0] bridge_wr_data;
  logic                          reset_button;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [core_pkg::mem_aw-1:0]   paddr;
  logic [core_pkg::bridge_w-1:0] pwdata;
  logic [core_pkg::bridge_w-1:0] prdata;
  logic                          pready;
  logic                          pslverr;
  logic                          core_reset;

  ////////////////////
  // reference model

  logic [core_pkg::bridge_w-1:0] shadow [core_pkg::mem_words];
  logic [core_pkg::mem_aw-1:0]   written [$];
  logic                          dl_flag;
  logic [15:0]                   timer_left;
  int                            errors;
  int                            cycles;

  core_top i_core_top (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .reset_button   (reset_button),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .core_reset     (core_reset)
  );

  // 8 ns period
  always #4 clk_74a = ~clk_74a;

  // run limit
  always @(posedge clk_74a) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // status word and zero elsewhere
  function automatic logic [core_pkg::bridge_w-1:0] exp_bridge_read(
    input logic [core_pkg::bridge_w-1:0] addr
  );
    logic [core_pkg::bridge_w-1:0] st;
    st = '0;
    st[0] = dl_flag;
    st[1] = dl_flag || (timer_left != '0);
    if (addr[31:24] == core_pkg::region_cmd && addr[3:2] == core_pkg::cmd_status_ofs) begin
      return st;
    end
    return '0;
  endfunction

  // {error, data} of one core access
  function automatic logic [core_pkg::bridge_w:0] exp_apb(
    input logic wr,
    input logic [core_pkg::mem_aw-1:0] addr
  );
    if (dl_flag || timer_left != '0) begin
      return {1'b1, {core_pkg::bridge_w{1'b0}}};
    end
    if (wr) begin
      return '0;
    end
    return {1'b0, shadow[addr]};
  endfunction

  ////////////////////
  // compare tasks

  task automatic check_word(input logic [core_pkg::bridge_w-1:0] got,
                            input logic [core_pkg::bridge_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_apb(input logic [core_pkg::bridge_w-1:0] got_data, input logic got_err,
                           input logic [core_pkg::bridge_w:0] exp, input string what);
    if ({got_err, got_data} !== exp) begin
      $display("FAIL t=%0t %s: got err %b data %h expected err %b data %h", $time, what,
               got_err, got_data, exp[core_pkg::bridge_w], exp[core_pkg::bridge_w-1:0]);
      errors++;
    end
  endtask

  task automatic check_span(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: %0d cycles expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // bus tasks

  // one bridge write, the model follows the region rules
  task automatic bridge_write(input logic [core_pkg::bridge_w-1:0] addr,
                              input logic [core_pkg::bridge_w-1:0] data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    if (addr[31:28] == core_pkg::region_load) begin
      shadow[addr[core_pkg::mem_aw+1:2]] = data;
    end else if (addr[31:24] == core_pkg::region_cmd) begin
      if (addr[3:2] == core_pkg::cmd_dl_start_ofs) begin
        dl_flag = 1'b1;
      end else if (addr[3:2] == core_pkg::cmd_dl_done_ofs) begin
        dl_flag = 1'b0;
      end
    end
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic load_write(input logic [core_pkg::mem_aw-1:0] addr,
                            input logic [core_pkg::bridge_w-1:0] data);
    bridge_write({core_pkg::region_load, 16'h0, addr, 2'b00}, data);
    written.push_back(addr);
  endtask

  task automatic bridge_read_check(input logic [core_pkg::bridge_w-1:0] addr, input string what);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_rd = 1'b1;
    @(negedge clk_74a);
    bridge_rd = 1'b0;
    check_word(bridge_rd_data, exp_bridge_read(addr), what);
  endtask

  // setup, access, then wait for pready sampled mid cycle
  task automatic apb_xfer(input logic wr, input logic [core_pkg::mem_aw-1:0] addr,
                          input logic [core_pkg::bridge_w-1:0] wdata,
                          output logic [core_pkg::bridge_w-1:0] rdata, output logic err);
    @(negedge clk_74a);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk_74a);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk_74a);
      #1;
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clk_74a);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [core_pkg::mem_aw-1:0] addr,
                           input logic [core_pkg::bridge_w-1:0] data, input string what);
    logic [core_pkg::bridge_w:0]   exp;
    logic [core_pkg::bridge_w-1:0] rdata;
    logic                          err;
    exp = exp_apb(1'b1, addr);
    apb_xfer(1'b1, addr, data, rdata, err);
    check_apb(rdata, err, exp, what);
    // memory changes only on a clean completion
    if (!exp[core_pkg::bridge_w]) begin
      shadow[addr] = data;
      written.push_back(addr);
    end
  endtask

  task automatic apb_read(input logic [core_pkg::mem_aw-1:0] addr, input string what);
    logic [core_pkg::bridge_w:0]   exp;
    logic [core_pkg::bridge_w-1:0] rdata;
    logic                          err;
    exp = exp_apb(1'b0, addr);
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_apb(rdata, err, exp, what);
  endtask

  ////////////////////
  // test sequence

  initial begin
    logic [core_pkg::mem_aw-1:0] a;
    logic [15:0]                 span;
    void'($urandom(32'h1676226b));
    clk_74a = 1'b0;
    rst_n = 1'b0;
    bridge_addr = '0;
    bridge_rd = 1'b0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    reset_button = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    dl_flag = 1'b0;
    timer_left = '0;
    errors = 0;
    cycles = 0;
    repeat (2) @(posedge clk_74a);
    @(negedge clk_74a);
    rst_n = 1'b1;

    // 1 loads then core reads
    repeat (16) load_write(core_pkg::mem_aw'($urandom_range(1023, 0)), $urandom());
    foreach (written[i]) apb_read(written[i], "load readback");

    // 2 back-to-back loads in the low half, core writes in the high half
    fork
      begin
        for (int i = 0; i < 24; i++) begin
          @(negedge clk_74a);
          a = core_pkg::mem_aw'($urandom_range(511, 0));
          bridge_addr = {core_pkg::region_load, 16'h0, a, 2'b00};
          bridge_wr_data = $urandom();
          bridge_wr = 1'b1;
          shadow[a] = bridge_wr_data;
          written.push_back(a);
        end
        @(negedge clk_74a);
        bridge_wr = 1'b0;
      end
      repeat (8) apb_write(core_pkg::mem_aw'($urandom_range(1023, 512)), $urandom(), "core wr");
    join
    // same word from both sides, loader lands first
    for (int i = 0; i < 3; i++) begin
      a = core_pkg::mem_aw'($urandom_range(1023, 0));
      fork
        load_write(a, $urandom());
        apb_write(a, $urandom(), "collision wr");
      join
    end
    foreach (written[i]) apb_read(written[i], "mixed readback");

    // 3 download flag in the status word
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_start_ofs, 2'b00}, '0);
    bridge_read_check({core_pkg::region_cmd, 20'h0, core_pkg::cmd_status_ofs, 2'b00}, "dl on");
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_done_ofs, 2'b00}, '0);
    bridge_read_check({core_pkg::region_cmd, 20'h0, core_pkg::cmd_status_ofs, 2'b00}, "dl off");

    // 4 button hold length
    @(negedge clk_74a);
    if (core_reset) begin
      $display("FAIL t=%0t core_reset was already high before the button press", $time);
      errors++;
    end
    reset_button = 1'b1;
    @(negedge clk_74a);
    reset_button = 1'b0;
    span = '0;
    timer_left = core_pkg::reset_hold_cycles;
    while (core_reset && span < 16'd256) begin
      span++;
      timer_left--;
      @(negedge clk_74a);
    end
    timer_left = '0;
    check_span(span, core_pkg::reset_hold_cycles, "button reset span");

    // 5 core access during reset
    a = written[0];
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_start_ofs, 2'b00}, '0);
    apb_write(a, ~shadow[a], "wr in reset");
    apb_read(a, "rd in reset");
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_done_ofs, 2'b00}, '0);
    apb_read(a, "unchanged after reset");

    // 6 reads that return zero
    // status word held nonzero so a read mux leaking it shows up
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_start_ofs, 2'b00}, '0);
    bridge_read_check(32'h1000_0040, "load region read");
    bridge_read_check(32'h2000_0000, "unmapped read");
    bridge_read_check(32'hF800_0008, "cmd non-status read");
    bridge_write({core_pkg::region_cmd, 20'h0, core_pkg::cmd_dl_done_ofs, 2'b00}, '0);

    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: word_ram.sv
/*
  single-port word ram, synchronous write, registered read
  read during write returns the old word
  no reset, contents are undefined until loaded
*/
`timescale 1ns/100ps

module word_ram (
  input  logic                          clk_74a,
  input  logic                          we,
  input  logic [core_pkg::mem_aw-1:0]   addr,
  input  logic [core_pkg::bridge_w-1:0] wdata,
  output logic [core_pkg::bridge_w-1:0] rdata
);

  logic [core_pkg::bridge_w-1:0] mem [core_pkg::mem_words];

  // write port
  always_ff @(posedge clk_74a) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // read port, data valid the cycle after addr
  always_ff @(posedge clk_74a) begin
    rdata <= mem[addr];
  end

endmodule
